// File: compile.f
rv_pkg.sv
rv_decoder.sv
if_stage.sv
id_stage.sv
hazard_unit.sv
ex_stage.sv
mem_wb_stage.sv
datapath.sv
rv_core.sv
tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_decoder.sv
  - if_stage.sv
  - id_stage.sv
  - hazard_unit.sv
  - ex_stage.sv
  - mem_wb_stage.sv
  - datapath.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

// File: tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
    import rv_pkg::*;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam word_t NOP       = 32'h0000_0013;
    localparam int    MARK_ADDR = 12'h3f0;
    localparam int    NUM_TESTS = 6;

    typedef struct packed {
        logic       marker;
        logic [2:0] test;
        logic [7:0] stalls;
        logic [7:0] flushes;
        word_t      addr;
        word_t      data;
    } exp_t;

    logic  clk;
    logic  rst_n_i     = 1'b0;
    word_t instr       = NOP;
    word_t ram_rdata   = '0;
    word_t rom_addr;
    word_t ram_addr;
    word_t ram_wdata;
    logic  ram_we;
    logic  ram_re;
    logic  stall;
    logic  flush;

    word_t rom [$];
    word_t ram [256];
    exp_t  exp_q [$];
    exp_t  head;
    logic  head_ok      = 1'b0;
    int    mismatch_cnt = 0;
    int    stray_cnt    = 0;
    int    errs_seen    = 0;
    int    pass_cnt     = 0;
    int    fail_cnt     = 0;
    int    tests_done   = 0;
    int    stall_cnt    = 0;
    int    flush_cnt    = 0;
    int    exp_stalls   = 0;
    int    exp_flushes  = 0;

    rv_core #(.RESET_PC(RESET_PC)) u_rv_core (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_i(instr), .ram_rdata_i(ram_rdata),
        .rom_addr_o(rom_addr), .ram_addr_o(ram_addr), .ram_wdata_o(ram_wdata),
        .ram_we_o(ram_we), .ram_re_o(ram_re), .stall_o(stall), .flush_o(flush)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // instruction encoding

    function automatic word_t r_type(input int f7, input int rs2, input int rs1,
                                     input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
    endfunction

    function automatic word_t i_type(input int imm, input int rs1, input int f3,
                                     input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t s_type(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t b_type(input int imm, input int rs2, input int rs1,
                                     input int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OP_BRANCH};
    endfunction

    function automatic word_t j_type(input int imm, input int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
    endfunction

    function automatic word_t sx12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // initial data memory contents
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "alu_forward";
            1:       return "load_use";
            2:       return "beq_taken";
            3:       return "bne";
            4:       return "jal_link";
            default: return "x0_write";
        endcase
    endfunction

    function automatic word_t rom_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        return (idx < rom.size()) ? rom[idx] : NOP;
    endfunction

    task automatic put(input word_t w);
        rom.push_back(w);
    endtask

    task automatic expect_store(input int addr, input word_t data, input int id,
                                input logic marker);
        exp_t e;
        e.marker  = marker;
        e.test    = 3'(id);
        e.stalls  = 8'(exp_stalls);
        e.flushes = 8'(exp_flushes);
        e.addr    = word_t'(addr);
        e.data    = data;
        exp_q.push_back(e);
    endtask

    task automatic store_checked(input int rs, input int addr, input word_t data,
                                 input int id);
        put(s_type(addr, rs, 0));
        expect_store(addr, data, id, 1'b0);
    endtask

    task automatic mark_end(input int id);
        put(i_type(id, 0, 0, 31, OP_IMM));
        put(s_type(MARK_ADDR, 31, 0));
        expect_store(MARK_ADDR, word_t'(id), id, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // program image and expected stores

    task automatic build_program();
        logic [11:0] r [6];
        word_t a, b, c, d, e, f, g, h, p;
        for (int i = 0; i < 6; i++) begin
            r[i] = 12'($urandom());
        end
        a = sx12(r[0]);
        b = a + sx12(r[1]);
        c = b + a;
        d = c - b;
        e = d ^ c;
        f = ($signed(e) < $signed(d)) ? 32'd1 : 32'd0;
        g = e & c;
        h = g | b;
        // each step consumes the previous result
        put(i_type(r[0], 0, 0, 1, OP_IMM));
        put(i_type(r[1], 1, 0, 2, OP_IMM));
        put(r_type(0, 1, 2, 0, 3));
        put(r_type(32, 2, 3, 0, 4));
        put(r_type(0, 3, 4, 4, 5));
        put(r_type(0, 4, 5, 2, 6));
        put(r_type(0, 3, 5, 7, 7));
        put(r_type(0, 2, 7, 6, 8));
        store_checked(8, 12'h100, h, 0);
        store_checked(7, 12'h104, g, 0);
        store_checked(6, 12'h108, f, 0);
        store_checked(5, 12'h10c, e, 0);
        store_checked(4, 12'h110, d, 0);
        store_checked(3, 12'h114, c, 0);
        mark_end(0);
        // lw then an immediate consumer
        put(i_type(r[2], 0, 0, 9, OP_IMM));
        put(i_type(12'h200, 0, 2, 10, OP_LOAD));
        put(r_type(0, 9, 10, 0, 11));
        exp_stalls++;
        store_checked(11, 12'h120, fill_word(32'h200) + sx12(r[2]), 1);
        mark_end(1);
        // beq over two stores
        put(i_type(r[3], 0, 0, 12, OP_IMM));
        put(i_type(r[3], 0, 0, 13, OP_IMM));
        put(b_type(12, 13, 12, 0));
        exp_flushes++;
        put(s_type(12'h130, 12, 0));
        put(s_type(12'h134, 13, 0));
        store_checked(12, 12'h138, sx12(r[3]), 2);
        mark_end(2);
        put(i_type(r[4], 0, 0, 14, OP_IMM));
        put(b_type(8, 14, 14, 1));
        store_checked(14, 12'h140, sx12(r[4]), 3);
        put(i_type(1, 14, 0, 15, OP_IMM));
        put(b_type(8, 15, 14, 1));
        exp_flushes++;
        put(s_type(12'h144, 15, 0));
        store_checked(15, 12'h148, sx12(r[4]) + 32'd1, 3);
        mark_end(3);
        p = RESET_PC + 32'(rom.size()) * 32'd4;
        put(j_type(8, 16));
        exp_flushes++;
        put(s_type(12'h150, 0, 0));
        store_checked(16, 12'h154, p + 32'd4, 4);
        mark_end(4);
        put(i_type(r[5] | 12'h1, 0, 0, 0, OP_IMM));
        store_checked(0, 12'h160, 32'h0, 5);
        mark_end(5);
        // park
        put(j_type(0, 0));
    endtask

    //////////////////////////////////////////////////
    // memories

    always @(negedge clk) begin
        instr     <= rom_word(rom_addr);
        ram_rdata <= ram_re ? ram[ram_addr[9:2]] : '0;
    end

    always @(posedge clk) begin
        if (ram_we) begin
            ram[ram_addr[9:2]] <= ram_wdata;
        end
    end

    //////////////////////////////////////////////////
    // store checking

    a_store_expected: assert property (@(negedge clk) disable iff (!rst_n_i)
        ram_we |-> head_ok)
        else begin
            $display("store to %h arrived while no store was expected", ram_addr);
            stray_cnt++;
        end

    a_store_matches: assert property (@(negedge clk) disable iff (!rst_n_i)
        ram_we && head_ok |-> ram_addr == head.addr && ram_wdata == head.data)
        else begin
            $display("MISMATCH %s: expected %h at %h, actual %h at %h",
                     test_name(int'(head.test)), head.data, head.addr, ram_wdata, ram_addr);
            mismatch_cnt++;
        end

    // stall and flush cycles seen before the marker store
    a_hazard_counts: assert property (@(negedge clk) disable iff (!rst_n_i)
        ram_we && head_ok && head.marker |->
            stall_cnt == int'(head.stalls) && flush_cnt == int'(head.flushes))
        else begin
            $display("MISMATCH %s: expected %0d stalls %0d flushes, actual %0d stalls %0d flushes",
                     test_name(int'(head.test)), head.stalls, head.flushes,
                     stall_cnt, flush_cnt);
            mismatch_cnt++;
        end

    task automatic report_test(input int id);
        int errs;
        errs      = mismatch_cnt - errs_seen;
        errs_seen = mismatch_cnt;
        $display("test %0d %s: %s, %0d errors", id, test_name(id),
                 (errs == 0) ? "ok" : "failed", errs);
        if (errs == 0) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
        end
        tests_done++;
    endtask

    always @(posedge clk) begin
        if (rst_n_i && stall) begin
            stall_cnt++;
        end
        if (rst_n_i && flush) begin
            flush_cnt++;
        end
        if (rst_n_i && ram_we && head_ok) begin
            if (head.marker) begin
                report_test(int'(head.test));
            end
            void'(exp_q.pop_front());
        end
        head_ok = (exp_q.size() != 0);
        if (head_ok) begin
            head = exp_q[0];
        end
    end

    initial begin
        int limit;
        int cycles;
        void'($urandom(32'hf4b7));
        build_program();
        for (int i = 0; i < 256; i++) begin
            ram[i] = fill_word(word_t'(i * 4));
        end
        limit  = rom.size() * 3 + 50;
        cycles = 0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        while (tests_done < NUM_TESTS && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (tests_done < NUM_TESTS) begin
            $display("program did not finish within %0d cycles", limit);
        end
        $display("tests passed %0d, failed %0d, stray stores %0d",
                 pass_cnt, fail_cnt, stray_cnt);
        if (tests_done == NUM_TESTS && fail_cnt == 0 && stray_cnt == 0 &&
            mismatch_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n_i,
    input  rv_pkg::word_t instr_i,
    input  rv_pkg::word_t ram_rdata_i,
    output rv_pkg::word_t rom_addr_o,
    output rv_pkg::word_t ram_addr_o,
    output rv_pkg::word_t ram_wdata_o,
    output logic          ram_we_o,
    output logic          ram_re_o,
    output logic          stall_o,
    output logic          flush_o
);
    import rv_pkg::*;

    word_t id_instr;
    ctrl_t ctrl;

    // control for the instruction sitting in ID
    rv_decoder u_rv_decoder (
        .instr_i(id_instr),
        .ctrl_o(ctrl)
    );

    datapath #(.RESET_PC(RESET_PC)) u_datapath (
        .clk(clk), .rst_n_i(rst_n_i),
        .instr_i(instr_i), .ctrl_i(ctrl), .ram_rdata_i(ram_rdata_i),
        .rom_addr_o(rom_addr_o), .id_instr_o(id_instr),
        .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o),
        .ram_we_o(ram_we_o), .ram_re_o(ram_re_o),
        .stall_o(stall_o), .flush_o(flush_o)
    );

endmodule

// File: datapath.sv
`timescale 1ns/10ps

module datapath #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic          clk,
    input  logic          rst_n_i,
    input  rv_pkg::word_t instr_i,
    input  rv_pkg::ctrl_t ctrl_i,
    input  rv_pkg::word_t ram_rdata_i,
    output rv_pkg::word_t rom_addr_o,
    output rv_pkg::word_t id_instr_o,
    output rv_pkg::word_t ram_addr_o,
    output rv_pkg::word_t ram_wdata_o,
    output logic          ram_we_o,
    output logic          ram_re_o,
    output logic          stall_o,
    output logic          flush_o
);
    import rv_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    mem_wb_t   mem_wb;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    fwd_sel_t  fwd_a;
    fwd_sel_t  fwd_b;
    logic      redirect;
    word_t     target;

    // decoder sits outside, in rv_core
    assign id_instr_o = if_id.instr;

    //////////////////////////////////////////////////
    // stages

    if_stage #(.RESET_PC(RESET_PC)) u_if_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_o), .redirect_i(redirect), .target_i(target),
        .instr_i(instr_i), .pc_o(rom_addr_o), .if_id_o(if_id)
    );

    id_stage u_id_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .stall_i(stall_o), .flush_i(flush_o), .if_id_i(if_id), .ctrl_i(ctrl_i),
        .mem_wb_i(mem_wb), .id_ex_o(id_ex), .rs1_o(id_rs1), .rs2_o(id_rs2)
    );

    hazard_unit u_hazard_unit (
        .rs1_i(id_rs1), .rs2_i(id_rs2), .id_ex_i(id_ex), .ex_mem_i(ex_mem),
        .mem_wb_i(mem_wb), .redirect_i(redirect),
        .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall_o), .flush_o(flush_o)
    );

    ex_stage u_ex_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .id_ex_i(id_ex), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b),
        .ex_mem_fwd_i(ex_mem.result), .wb_fwd_i(mem_wb.wb_data),
        .ex_mem_o(ex_mem), .redirect_o(redirect), .target_o(target)
    );

    mem_wb_stage u_mem_wb_stage (
        .clk(clk), .rst_n_i(rst_n_i),
        .ex_mem_i(ex_mem), .ram_rdata_i(ram_rdata_i),
        .ram_addr_o(ram_addr_o), .ram_wdata_o(ram_wdata_o),
        .ram_we_o(ram_we_o), .ram_re_o(ram_re_o), .mem_wb_o(mem_wb)
    );

endmodule

// File: mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage (
    input  logic            clk,
    input  logic            rst_n_i,
    input  rv_pkg::ex_mem_t ex_mem_i,
    input  rv_pkg::word_t   ram_rdata_i,
    output rv_pkg::word_t   ram_addr_o,
    output rv_pkg::word_t   ram_wdata_o,
    output logic            ram_we_o,
    output logic            ram_re_o,
    output rv_pkg::mem_wb_t mem_wb_o
);
    import rv_pkg::*;

    mem_wb_t mem_wb_q;

    assign ram_addr_o  = ex_mem_i.result;
    assign ram_wdata_o = ex_mem_i.store_data;
    assign ram_we_o    = ex_mem_i.valid && ex_mem_i.mem_write;
    assign ram_re_o    = ex_mem_i.valid && ex_mem_i.mem_read;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wb_q.valid     <= 1'b0;
            mem_wb_q.reg_write <= 1'b0;
        end else begin
            mem_wb_q.valid     <= ex_mem_i.valid;
            mem_wb_q.reg_write <= ex_mem_i.valid && ex_mem_i.reg_write;
            mem_wb_q.rd        <= ex_mem_i.rd;
            mem_wb_q.wb_data   <= ex_mem_i.mem_read ? ram_rdata_i : ex_mem_i.result;
        end
    end

    assign mem_wb_o = mem_wb_q;

    a_we_re_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ram_we_o && ram_re_o))
        else $error("data memory read and write in one cycle");

endmodule

// File: ex_stage.sv
`timescale 1ns/10ps

module ex_stage (
    input  logic             clk,
    input  logic             rst_n_i,
    input  rv_pkg::id_ex_t   id_ex_i,
    input  rv_pkg::fwd_sel_t fwd_a_i,
    input  rv_pkg::fwd_sel_t fwd_b_i,
    input  rv_pkg::word_t    ex_mem_fwd_i,
    input  rv_pkg::word_t    wb_fwd_i,
    output rv_pkg::ex_mem_t  ex_mem_o,
    output logic             redirect_o,
    output rv_pkg::word_t    target_o
);
    import rv_pkg::*;

    word_t   op_a;
    word_t   rs2_val;
    word_t   op_b;
    word_t   alu_res;
    logic    taken;
    ex_mem_t ex_mem_q;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        word_t v;
        case (sel)
            FWD_MEM: v = mem_val;
            FWD_WB:  v = wb_val;
            default: v = reg_val;
        endcase
        return v;
    endfunction

    assign op_a    = fwd_mux(fwd_a_i, id_ex_i.rs1_data, ex_mem_fwd_i, wb_fwd_i);
    assign rs2_val = fwd_mux(fwd_b_i, id_ex_i.rs2_data, ex_mem_fwd_i, wb_fwd_i);
    assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_val;

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            ALU_SUB: alu_res = op_a - op_b;
            ALU_AND: alu_res = op_a & op_b;
            ALU_OR:  alu_res = op_a | op_b;
            ALU_XOR: alu_res = op_a ^ op_b;
            ALU_SLT: alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            default: alu_res = op_a + op_b;
        endcase
    end

    //////////////////////////////////////////////////
    // branch resolution

    // bubbles carry no control
    assign taken = id_ex_i.ctrl.branch &&
                   (id_ex_i.ctrl.branch_ne ? (op_a != rs2_val) : (op_a == rs2_val));
    assign redirect_o = taken || id_ex_i.ctrl.jal;
    assign target_o   = id_ex_i.pc + id_ex_i.imm;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_q.valid     <= 1'b0;
            ex_mem_q.reg_write <= 1'b0;
            ex_mem_q.mem_read  <= 1'b0;
            ex_mem_q.mem_write <= 1'b0;
        end else begin
            ex_mem_q.valid      <= id_ex_i.valid;
            ex_mem_q.reg_write  <= id_ex_i.valid && id_ex_i.ctrl.reg_write;
            ex_mem_q.mem_read   <= id_ex_i.valid && id_ex_i.ctrl.mem_read;
            ex_mem_q.mem_write  <= id_ex_i.valid && id_ex_i.ctrl.mem_write;
            ex_mem_q.rd         <= id_ex_i.rd;
            // link address for jal
            ex_mem_q.result     <= id_ex_i.ctrl.jal ? id_ex_i.pc + 32'd4 : alu_res;
            ex_mem_q.store_data <= rs2_val;
        end
    end

    assign ex_mem_o = ex_mem_q;

    a_redirect_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        redirect_o |-> id_ex_i.valid)
        else $error("redirect from an invalid EX entry");

    // x0 operand after forwarding
    a_x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        id_ex_i.valid |-> (id_ex_i.rs1 != '0 || op_a == '0) &&
                          (id_ex_i.rs2 != '0 || rs2_val == '0))
        else $error("x0 read returned nonzero data");

endmodule

// File: hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit (
    input  rv_pkg::reg_addr_t rs1_i,
    input  rv_pkg::reg_addr_t rs2_i,
    input  rv_pkg::id_ex_t    id_ex_i,
    input  rv_pkg::ex_mem_t   ex_mem_i,
    input  rv_pkg::mem_wb_t   mem_wb_i,
    input  logic              redirect_i,
    output rv_pkg::fwd_sel_t  fwd_a_o,
    output rv_pkg::fwd_sel_t  fwd_b_o,
    output logic              stall_o,
    output logic              flush_o
);
    import rv_pkg::*;

    // younger producer wins
    function automatic fwd_sel_t pick_src(input reg_addr_t rs, input ex_mem_t em,
                                          input mem_wb_t mw);
        fwd_sel_t sel;
        sel = FWD_NONE;
        if (em.valid && em.reg_write && em.rd != '0 && em.rd == rs) begin
            sel = FWD_MEM;
        end else if (mw.valid && mw.reg_write && mw.rd != '0 && mw.rd == rs) begin
            sel = FWD_WB;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_src(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = pick_src(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // load in EX feeding the instruction in ID
    assign stall_o = id_ex_i.valid && id_ex_i.ctrl.mem_read && (id_ex_i.rd != '0) &&
                     ((id_ex_i.rd == rs1_i) || (id_ex_i.rd == rs2_i));

    assign flush_o = redirect_i;

    // a redirecting instruction is never a load
    a_no_stall_on_flush: assert final (!(stall_o && flush_o))
        else $error("stall and flush raised together");

endmodule

// File: id_stage.sv
`timescale 1ns/10ps

module id_stage (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  rv_pkg::if_id_t    if_id_i,
    input  rv_pkg::ctrl_t     ctrl_i,
    input  rv_pkg::mem_wb_t   mem_wb_i,
    output rv_pkg::id_ex_t    id_ex_o,
    output rv_pkg::reg_addr_t rs1_o,
    output rv_pkg::reg_addr_t rs2_o
);
    import rv_pkg::*;

    word_t     regs [31:1];
    word_t     instr;
    word_t     imm;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      wr_en;
    id_ex_t    id_ex_q;

    assign instr = if_id_i.instr;
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign wr_en = mem_wb_i.valid && mem_wb_i.reg_write && (mem_wb_i.rd != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[mem_wb_i.rd] <= mem_wb_i.wb_data;
        end
    end

    // write-through lets WB and ID meet in one cycle
    assign rs1_data = (rs1 == '0) ? '0 :
                      (wr_en && rs1 == mem_wb_i.rd) ? mem_wb_i.wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 :
                      (wr_en && rs2 == mem_wb_i.rd) ? mem_wb_i.wb_data : regs[rs2];

    always_comb begin
        case (instr[6:0])
            OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default:   imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_q.valid <= 1'b0;
            id_ex_q.ctrl  <= '0;
        end else begin
            // bubble
            if (flush_i || stall_i || !if_id_i.valid) begin
                id_ex_q.valid <= 1'b0;
                id_ex_q.ctrl  <= '0;
            end else begin
                id_ex_q.valid <= 1'b1;
                id_ex_q.ctrl  <= ctrl_i;
            end
            id_ex_q.pc       <= if_id_i.pc;
            id_ex_q.rs1      <= rs1;
            id_ex_q.rs2      <= rs2;
            id_ex_q.rd       <= instr[11:7];
            id_ex_q.rs1_data <= rs1_data;
            id_ex_q.rs2_data <= rs2_data;
            id_ex_q.imm      <= imm;
        end
    end

    assign id_ex_o = id_ex_q;
    assign rs1_o   = rs1;
    assign rs2_o   = rs2;

endmodule

// File: if_stage.sv
`timescale 1ns/10ps

module if_stage #(
    parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst_n_i,
    input  logic           stall_i,
    input  logic           redirect_i,
    input  rv_pkg::word_t  target_i,
    input  rv_pkg::word_t  instr_i,
    output rv_pkg::word_t  pc_o,
    output rv_pkg::if_id_t if_id_o
);
    import rv_pkg::*;

    word_t  pc_q;
    if_id_t if_id_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q          <= RESET_PC;
            if_id_q.valid <= 1'b0;
        end else if (redirect_i) begin
            // the fetch in flight is on the wrong path
            pc_q          <= target_i;
            if_id_q.valid <= 1'b0;
        end else if (!stall_i) begin
            pc_q          <= pc_q + 32'd4;
            if_id_q.valid <= 1'b1;
            if_id_q.pc    <= pc_q;
            if_id_q.instr <= instr_i;
        end
    end

    assign pc_o    = pc_q;
    assign if_id_o = if_id_q;

endmodule

// File: rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::word_t instr_i,
    output rv_pkg::ctrl_t ctrl_o
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_5;

    assign opcode   = instr_i[6:0];
    assign funct3   = instr_i[14:12];
    assign funct7_5 = instr_i[30];

    always_comb begin
        // anything not decoded stays a no-op
        ctrl_o = '0;
        case (opcode)
            OP_REG: begin
                ctrl_o.reg_write = 1'b1;
                case (funct3)
                    3'b000:  ctrl_o.alu_op = funct7_5 ? ALU_SUB : ALU_ADD;
                    3'b111:  ctrl_o.alu_op = ALU_AND;
                    3'b110:  ctrl_o.alu_op = ALU_OR;
                    3'b100:  ctrl_o.alu_op = ALU_XOR;
                    3'b010:  ctrl_o.alu_op = ALU_SLT;
                    default: ctrl_o.reg_write = 1'b0;
                endcase
            end
            OP_IMM: begin
                // addi only
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = (funct3 == 3'b000);
            end
            OP_LOAD: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = (funct3 == 3'b010);
                ctrl_o.mem_read  = (funct3 == 3'b010);
            end
            OP_STORE: begin
                ctrl_o.alu_op    = ALU_ADD;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_write = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                ctrl_o.alu_op    = ALU_SUB;
                ctrl_o.branch    = (funct3 == 3'b000) || (funct3 == 3'b001);
                ctrl_o.branch_ne = (funct3 == 3'b001);
            end
            OP_JAL: begin
                ctrl_o.reg_write = 1'b1;
                ctrl_o.jal       = 1'b1;
            end
            default: ctrl_o = '0;
        endcase
    end

endmodule

// File: rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  fwd_sel_t;

    localparam alu_op_t ALU_ADD = 4'd0;
    localparam alu_op_t ALU_SUB = 4'd1;
    localparam alu_op_t ALU_AND = 4'd2;
    localparam alu_op_t ALU_OR  = 4'd3;
    localparam alu_op_t ALU_XOR = 4'd4;
    localparam alu_op_t ALU_SLT = 4'd5;

    // forwarding source for an EX operand
    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    branch_ne;
        logic    jal;
    } ctrl_t;

    //////////////////////////////////////////////////
    // pipeline registers

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        reg_addr_t rd;
        word_t     result;
        word_t     store_data;
    } ex_mem_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write;
        reg_addr_t rd;
        word_t     wb_data;
    } mem_wb_t;

endpackage
